//--- l1_split_cache.f
+incdir+source
source/cache_cmd_pkg.sv
source/cache_line_pkg.sv
source/trace_decode.sv
source/tag_store.sv
source/way_lookup.sv
source/line_update.sv
source/l1_split_cache.sv
sim/tb_clock_gen.sv
sim/tb_l1_split_cache.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it from the project root and look for the pass line
verilator --binary --timing --assert --top-module tb_l1_split_cache \
    -f l1_split_cache.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "run passed" || { echo "run failed"; exit 1; }

//--- sim/l1_split_cache_stim.txt
// columns are op code, byte address and expected hit flag, all in hex
// most traffic goes to data set 1 and instruction set 1
0 00000040 0  // read miss fills way 0
0 00000040 1
1 00000040 1  // write hit makes the line modified
0 00000440 0
0 00000840 0
0 00000c40 0
0 00001040 0
0 00001440 0
0 00001840 0
0 00001c40 0
0 00002040 0  // ninth tag evicts the modified way 0
2 00000840 0  // fetch misses although data holds this address
2 00000840 1
1 00000840 1
4 00000840 1  // snoop turns modified into shared
3 00000440 1
4 00000440 0
3 00003040 0
8 00000000 0
0 00000840 0
2 00000840 0
0 00000840 1

//--- sim/tb_l1_split_cache.sv
// testbench for the split L1 tag controller, trace stimulus, reference model and response checks
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tb_l1_split_cache;

    import cache_cmd_pkg::*;
    import cache_line_pkg::*;

    typedef struct packed {
        int op;
        int hit;
        int way;
        int evict;
        int wb;
        int mesi;
    } exp_t;

    logic        clk, rst_n;
    logic        cmd_valid, cmd_ready, resp_valid, resp_ready;
    cache_cmd_t  cmd;
    cache_resp_t resp;

    logic [3:0]  op_q [$];
    logic [31:0] addr_q [$];
    logic        file_hit_q [$];  // hit column of the stimulus file
    exp_t        exp_q [$];
    exp_t        pred;

    // reference copy of both tag arrays, cache 0 is data and cache 1 is instruction
    logic [`D_TAG_W:0] m_tag [2][16][8];
    int                m_mesi [2][16][8];
    int                m_age [2][16][8];

    int          seed = 70096;
    int          errors, hits, done, sent, cycles, limit, fd, rc;
    logic        cmd_fire = 1'b0;
    string       line;
    logic [3:0]  f_op;
    logic [31:0] f_addr;
    logic        f_hit;

    tb_clock_gen u_clk (.clk_o (clk));

    l1_split_cache UUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .cmd_valid_i  (cmd_valid),
        .cmd_ready_o  (cmd_ready),
        .cmd_i        (cmd),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .resp_o       (resp)
    );

    task automatic clear_model();
        for (int c = 0; c < 2; c++) begin
            for (int s = 0; s < 16; s++) begin
                for (int w = 0; w < 8; w++) begin
                    m_tag[c][s][w]  = '0;
                    m_mesi[c][s][w] = 0;
                    m_age[c][s][w]  = 0;
                end
            end
        end
    endtask

    // applies one command to the model and returns the response it expects
    task automatic predict(input logic [3:0] op, input logic [31:0] addr, output exp_t e);
        logic              ic, hit, inv;
        logic [`D_TAG_W:0] tag;
        int                idx, nw, hw, vw, way, old_age, max_age;
        e       = '0;
        e.op    = int'(op);
        ic      = (op == 4'd2);
        idx     = ic ? int'(addr[8:6]) : int'(addr[9:6]);  // index sits above the line offset
        tag     = ic ? addr[31:9] : {1'b0, addr[31:10]};
        nw      = ic ? 4 : 8;
        hit     = 1'b0;
        inv     = 1'b0;
        hw      = 0;
        vw      = 0;
        max_age = -1;
        if (op == 4'd8) begin
            clear_model();
        end else begin
            for (int w = 0; w < nw; w++) begin
                if (!hit && m_mesi[ic][idx][w] != 0 && m_tag[ic][idx][w] == tag) begin
                    hit = 1'b1;
                    hw  = w;
                end
                if (!inv && m_mesi[ic][idx][w] == 0) begin
                    inv = 1'b1;
                    vw  = w;
                end
            end
            for (int w = 0; w < nw && !inv; w++) begin  // oldest way, ties to the lowest
                if (m_age[ic][idx][w] > max_age) begin
                    max_age = m_age[ic][idx][w];
                    vw      = w;
                end
            end
            way   = hit ? hw : vw;
            e.hit = int'(hit);
            e.way = way;
            if (op <= 4'd2) begin
                old_age = m_age[ic][idx][way];
                for (int w = 0; w < nw; w++) begin
                    if (hit ? (m_age[ic][idx][w] < old_age)
                            : (m_mesi[ic][idx][w] != 0 && m_age[ic][idx][w] < 7)) begin
                        m_age[ic][idx][w]++;
                    end
                end
                if (!hit) begin
                    e.evict = int'(m_mesi[ic][idx][way] != 0);
                    e.wb    = int'(m_mesi[ic][idx][way] == 3);
                end
                m_tag[ic][idx][way] = tag;
                m_age[ic][idx][way] = 0;
                if (op == 4'd1) begin
                    m_mesi[ic][idx][way] = 3;
                end else if (!hit) begin
                    m_mesi[ic][idx][way] = 2;  // fill as exclusive
                end
                e.mesi = m_mesi[ic][idx][way];
            end else if (op == 4'd3) begin
                if (hit) begin
                    m_mesi[ic][idx][way] = 0;
                end
            end else if (hit) begin
                if (m_mesi[ic][idx][way] >= 2) begin
                    m_mesi[ic][idx][way] = 1;  // snoop leaves a shared copy
                end
                e.mesi = m_mesi[ic][idx][way];
            end
        end
    endtask

    task automatic compare_field(input string name, input int exp_v, input int act_v);
        assert (act_v == exp_v) else begin
            $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_response();
        exp_t e;
        if (exp_q.size() == 0) begin
            $display("a response arrived at %0t ns with no command outstanding", $time);
            errors++;
        end else begin
            e = exp_q.pop_front();
            compare_field("resp_o.op", e.op, int'(resp.op));
            compare_field("resp_o.hit", e.hit, int'(resp.hit));
            compare_field("resp_o.way", e.way, int'(resp.way));
            compare_field("resp_o.evict", e.evict, int'(resp.evict));
            compare_field("resp_o.writeback", e.wb, int'(resp.writeback));
            compare_field("resp_o.mesi", e.mesi, int'(resp.mesi));
            compare_field("resp_o.hit", int'(file_hit_q[done]), int'(resp.hit));
            if (resp.hit) begin
                hits++;
            end
        end
        done++;
    endtask

    initial begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        resp_ready = 1'b0;
        clear_model();
        fd = $fopen("sim/l1_split_cache_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0) begin
                    if ($sscanf(line, "%h %h %h", f_op, f_addr, f_hit) == 3) begin
                        op_q.push_back(f_op);
                        addr_q.push_back(f_addr);
                        file_hit_q.push_back(f_hit);
                    end
                end
            end
            $fclose(fd);
        end
        if (op_q.size() == 0) begin
            $display("no commands could be read from the stimulus file");
            errors++;
        end
        limit = (op_q.size() * 3 + 3) * 8;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (done < op_q.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (cmd_fire) begin
                cmd_valid = 1'b0;  // taken on the last rising edge
            end
            if (!cmd_valid && sent < op_q.size()) begin
                cmd       = {op_q[sent], addr_q[sent]};
                cmd_valid = 1'b1;
            end
            resp_ready = (($random(seed) & 3) != 0);
            #2;
            cmd_fire = cmd_valid && cmd_ready;
            if (cmd_fire) begin
                predict(op_q[sent], addr_q[sent], pred);
                exp_q.push_back(pred);
                sent++;
            end
            if (resp_valid && resp_ready) begin
                check_response();
            end
        end
        if (done < op_q.size()) begin
            $display("timeout after %0d cycles, only %0d of %0d responses arrived",
                     cycles, done, op_q.size());
            errors++;
        end

        $display("responses %0d, hits %0d, errors %0d", done, hits, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
// testbench clock source with a 20 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;  // half period
    end

endmodule

`default_nettype wire

//--- source/l1_split_cache.sv
// split L1 cache tag and state controller, decode, lookup and update around the tag store
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module l1_split_cache (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire                         cmd_valid_i,
    output logic                        cmd_ready_o,
    input  wire cache_cmd_pkg::cache_cmd_t cmd_i,
    output logic                        resp_valid_o,
    input  wire                         resp_ready_i,
    output cache_line_pkg::cache_resp_t resp_o
);

    import cache_cmd_pkg::*;
    import cache_line_pkg::*;

    logic                  dec_valid, dec_ready;
    dec_cmd_t              dec;
    logic                  rd_icache;
    logic [`D_INDEX_W-1:0] rd_index;
    cache_line_t           rd_set [`D_WAYS];
    logic                  busy_valid, busy_icache;
    logic [`D_INDEX_W-1:0] busy_index;
    logic                  lk_valid, lk_ready;
    lookup_t               lk;
    cache_line_t           lk_set [`D_WAYS];
    logic                  wr_en, wr_icache, clear;
    logic [`D_INDEX_W-1:0] wr_index;
    cache_line_t           wr_set [`D_WAYS];

    trace_decode u_decode (
        .clk_i, .rst_n_i, .cmd_valid_i, .cmd_ready_o, .cmd_i,
        .dec_valid_o (dec_valid), .dec_ready_i (dec_ready), .dec_o (dec)
    );

    way_lookup u_lookup (
        .clk_i, .rst_n_i,
        .dec_valid_i (dec_valid), .dec_ready_o (dec_ready), .dec_i (dec),
        .rd_icache_o (rd_icache), .rd_index_o (rd_index), .rd_set_i (rd_set),
        .busy_valid_i (busy_valid), .busy_icache_i (busy_icache), .busy_index_i (busy_index),
        .lk_valid_o (lk_valid), .lk_ready_i (lk_ready), .lk_o (lk), .lk_set_o (lk_set)
    );

    tag_store u_store (
        .clk_i, .rst_n_i,
        .rd_icache_i (rd_icache), .rd_index_i (rd_index), .rd_set_o (rd_set),
        .wr_en_i (wr_en), .wr_icache_i (wr_icache), .wr_index_i (wr_index),
        .wr_set_i (wr_set), .clear_i (clear)
    );

    line_update u_update (
        .clk_i, .rst_n_i,
        .lk_valid_i (lk_valid), .lk_ready_o (lk_ready), .lk_i (lk), .set_i (lk_set),
        .busy_valid_o (busy_valid), .busy_icache_o (busy_icache), .busy_index_o (busy_index),
        .wr_en_o (wr_en), .wr_icache_o (wr_icache), .wr_index_o (wr_index),
        .wr_set_o (wr_set), .clear_o (clear),
        .resp_valid_o, .resp_ready_i, .resp_o
    );

endmodule

`default_nettype wire

//--- source/line_update.sv
// result stage, next MESI and LRU ages, set write back and response register
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module line_update (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire                         lk_valid_i,
    output logic                        lk_ready_o,
    input  wire cache_line_pkg::lookup_t lk_i,
    input  wire cache_line_pkg::cache_line_t set_i [`D_WAYS],
    output logic                        busy_valid_o,
    output logic                        busy_icache_o,
    output logic [`D_INDEX_W-1:0]       busy_index_o,
    output logic                        wr_en_o,
    output logic                        wr_icache_o,
    output logic [`D_INDEX_W-1:0]       wr_index_o,
    output cache_line_pkg::cache_line_t wr_set_o [`D_WAYS],
    output logic                        clear_o,
    output logic                        resp_valid_o,
    input  wire                         resp_ready_i,
    output cache_line_pkg::cache_resp_t resp_o
);

    import cache_cmd_pkg::*;
    import cache_line_pkg::*;

    logic [`WAY_W:0] nways;
    cache_line_t     new_set [`D_WAYS];
    cache_resp_t     resp_d;
    logic            lk_fire;

    assign nways = lk_i.cmd.icache ? (`WAY_W+1)'(`I_WAYS) : (`WAY_W+1)'(`D_WAYS);

    always_comb begin
        new_set = set_i;
        resp_d  = '{op: lk_i.cmd.op, hit: lk_i.hit, way: lk_i.way,
                    evict: 1'b0, writeback: 1'b0, mesi: MESI_I};
        case (lk_i.cmd.op)
            OP_DREAD, OP_DWRITE, OP_IFETCH: begin
                for (int w = 0; w < `D_WAYS; w++) begin
                    if (w < int'(nways) && set_i[w].age != '1) begin
                        // hit ages only the younger ways, miss ages every valid way
                        if (lk_i.hit ? (set_i[w].age < lk_i.line.age)
                                     : (set_i[w].mesi != MESI_I)) begin
                            new_set[w].age = set_i[w].age + 1'b1;
                        end
                    end
                end
                new_set[lk_i.way].tag = lk_i.cmd.tag;
                new_set[lk_i.way].age = '0;
                if (lk_i.cmd.op == OP_DWRITE) begin
                    new_set[lk_i.way].mesi = MESI_M;
                end else if (!lk_i.hit) begin
                    new_set[lk_i.way].mesi = MESI_E;  // fill
                end
                resp_d.evict     = !lk_i.hit && (lk_i.line.mesi != MESI_I);
                resp_d.writeback = !lk_i.hit && (lk_i.line.mesi == MESI_M);
                resp_d.mesi      = new_set[lk_i.way].mesi;
            end
            OP_INVAL: begin
                if (lk_i.hit) begin
                    new_set[lk_i.way].mesi = MESI_I;
                end
            end
            OP_SNOOP: begin
                if (lk_i.hit && (lk_i.line.mesi == MESI_M || lk_i.line.mesi == MESI_E)) begin
                    new_set[lk_i.way].mesi = MESI_S;
                end
                if (lk_i.hit) begin
                    resp_d.mesi = new_set[lk_i.way].mesi;
                end
            end
            default: begin  // clear
                resp_d.hit = 1'b0;
                resp_d.way = '0;
            end
        endcase
    end

    assign lk_ready_o = !resp_valid_o || resp_ready_i;
    assign lk_fire    = lk_valid_i && lk_ready_o;

    // store is written on the same edge that registers the response
    assign wr_en_o     = lk_fire && !lk_i.cmd.clear;
    assign clear_o     = lk_fire && lk_i.cmd.clear;
    assign wr_icache_o = lk_i.cmd.icache;
    assign wr_index_o  = lk_i.cmd.index;
    assign wr_set_o    = new_set;

    assign busy_valid_o  = lk_valid_i;
    assign busy_icache_o = lk_i.cmd.icache;
    assign busy_index_o  = lk_i.cmd.index;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            resp_valid_o <= 1'b0;
        end else if (lk_ready_o) begin
            resp_valid_o <= lk_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lk_fire) begin
            resp_o <= resp_d;
        end
    end

endmodule

`default_nettype wire

//--- source/way_lookup.sv
// execute stage, tag compare with hit or victim way choice and same set stall
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module way_lookup (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire                         dec_valid_i,
    output logic                        dec_ready_o,
    input  wire cache_cmd_pkg::dec_cmd_t dec_i,
    output logic                        rd_icache_o,
    output logic [`D_INDEX_W-1:0]       rd_index_o,
    input  wire cache_line_pkg::cache_line_t rd_set_i [`D_WAYS],
    input  wire                         busy_valid_i,
    input  wire                         busy_icache_i,
    input  wire [`D_INDEX_W-1:0]        busy_index_i,
    output logic                        lk_valid_o,
    input  wire                         lk_ready_i,
    output cache_line_pkg::lookup_t     lk_o,
    output cache_line_pkg::cache_line_t lk_set_o [`D_WAYS]
);

    import cache_line_pkg::*;

    logic [`WAY_W:0]   nways;
    logic              hit, inv_found;
    logic [`WAY_W-1:0] hit_way, inv_way, old_way, sel_way;
    logic [`AGE_W-1:0] old_age;
    logic              same_set, stall, can_load;
    lookup_t           lk_d;

    assign rd_icache_o = dec_i.icache;
    assign rd_index_o  = dec_i.index;
    assign nways       = dec_i.icache ? (`WAY_W+1)'(`I_WAYS) : (`WAY_W+1)'(`D_WAYS);

    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        inv_found = 1'b0;
        inv_way   = '0;
        old_way   = '0;
        old_age   = rd_set_i[0].age;
        for (int w = 0; w < `D_WAYS; w++) begin
            if (w < int'(nways)) begin
                if (!hit && rd_set_i[w].mesi != MESI_I && rd_set_i[w].tag == dec_i.tag) begin
                    hit     = 1'b1;  // lowest hit way wins
                    hit_way = `WAY_W'(w);
                end
                if (!inv_found && rd_set_i[w].mesi == MESI_I) begin
                    inv_found = 1'b1;
                    inv_way   = `WAY_W'(w);
                end
                if (rd_set_i[w].age > old_age) begin  // strict, ties stay low
                    old_age = rd_set_i[w].age;
                    old_way = `WAY_W'(w);
                end
            end
        end
    end

    assign sel_way = hit ? hit_way : (inv_found ? inv_way : old_way);
    assign lk_d    = '{cmd: dec_i, hit: hit && !dec_i.clear, way: sel_way,
                       line: rd_set_i[sel_way]};

    // wait for the update stage to write back a set we are about to read
    assign same_set    = (busy_icache_i == dec_i.icache) && (busy_index_i == dec_i.index);
    assign stall       = busy_valid_i && !dec_i.clear && (same_set || lk_o.cmd.clear);
    assign can_load    = !lk_valid_o || lk_ready_i;
    assign dec_ready_o = can_load && !stall;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lk_valid_o <= 1'b0;
        end else if (can_load) begin
            lk_valid_o <= dec_valid_i && !stall;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_valid_i && dec_ready_o) begin
            lk_o     <= lk_d;
            lk_set_o <= rd_set_i;  // old set travels with the lookup
        end
    end

endmodule

`default_nettype wire

//--- source/tag_store.sv
// tag, MESI and age arrays of both caches with one read set and one write set
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tag_store (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire                         rd_icache_i,
    input  wire [`D_INDEX_W-1:0]        rd_index_i,
    output cache_line_pkg::cache_line_t rd_set_o [`D_WAYS],
    input  wire                         wr_en_i,
    input  wire                         wr_icache_i,
    input  wire [`D_INDEX_W-1:0]        wr_index_i,
    input  wire cache_line_pkg::cache_line_t wr_set_i [`D_WAYS],
    input  wire                         clear_i
);

    import cache_line_pkg::*;

    cache_line_t d_lines [1<<`D_INDEX_W][`D_WAYS];
    cache_line_t i_lines [1<<`I_INDEX_W][`I_WAYS];

    // instruction set sits in the low ways, upper ways read as invalid
    always_comb begin
        for (int w = 0; w < `D_WAYS; w++) begin
            rd_set_o[w] = rd_icache_i ? '0 : d_lines[rd_index_i][w];
        end
        if (rd_icache_i) begin
            for (int w = 0; w < `I_WAYS; w++) begin
                rd_set_o[w] = i_lines[rd_index_i[`I_INDEX_W-1:0]][w];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            for (int s = 0; s < (1<<`D_INDEX_W); s++) begin
                for (int w = 0; w < `D_WAYS; w++) begin
                    d_lines[s][w] <= '0;  // state I, age 0
                end
            end
            for (int s = 0; s < (1<<`I_INDEX_W); s++) begin
                for (int w = 0; w < `I_WAYS; w++) begin
                    i_lines[s][w] <= '0;
                end
            end
        end else if (wr_en_i) begin
            if (wr_icache_i) begin
                for (int w = 0; w < `I_WAYS; w++) begin
                    i_lines[wr_index_i[`I_INDEX_W-1:0]][w] <= wr_set_i[w];
                end
            end else begin
                d_lines[wr_index_i] <= wr_set_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/trace_decode.sv
// decode stage, picks the cache and address view for each accepted trace command
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module trace_decode (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  wire                       cmd_valid_i,
    output logic                      cmd_ready_o,
    input  wire cache_cmd_pkg::cache_cmd_t cmd_i,
    output logic                      dec_valid_o,
    input  wire                       dec_ready_i,
    output cache_cmd_pkg::dec_cmd_t   dec_o
);

    import cache_cmd_pkg::*;

    dec_cmd_t dec_d;

    always_comb begin
        dec_d        = '0;
        dec_d.op     = cmd_i.op;
        dec_d.icache = (cmd_i.op == OP_IFETCH);
        dec_d.clear  = (cmd_i.op == OP_CLEAR);
        if (dec_d.icache) begin
            dec_d.index = {{(`D_INDEX_W-`I_INDEX_W){1'b0}}, cmd_i.addr.i.index};
            dec_d.tag   = cmd_i.addr.i.tag;
        end else begin
            dec_d.index = cmd_i.addr.d.index;
            dec_d.tag   = {1'b0, cmd_i.addr.d.tag};
        end
    end

    assign cmd_ready_o = !dec_valid_o || dec_ready_i;  // slice empty or draining

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else if (cmd_ready_o) begin
            dec_valid_o <= cmd_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_valid_i && cmd_ready_o) begin
            dec_o <= dec_d;
        end
    end

endmodule

`default_nettype wire

//--- source/cache_line_pkg.sv
// line state and pipeline result types for the split L1 controller
`default_nettype none

`include "cache_cfg.svh"

package cache_line_pkg;

    import cache_cmd_pkg::*;

    typedef enum logic [1:0] {
        MESI_I = 2'd0,
        MESI_S = 2'd1,
        MESI_E = 2'd2,
        MESI_M = 2'd3
    } mesi_e;

    typedef struct packed {
        logic [`D_TAG_W:0]   tag;
        mesi_e               mesi;
        logic [`AGE_W-1:0]   age;   // 0 is most recently used
    } cache_line_t;

    // lookup result handed to the update stage
    typedef struct packed {
        dec_cmd_t            cmd;
        logic                hit;
        logic [`WAY_W-1:0]   way;   // hit way, or victim on a miss
        cache_line_t         line;  // old contents of that way
    } lookup_t;

    typedef struct packed {
        cache_op_e           op;
        logic                hit;
        logic [`WAY_W-1:0]   way;
        logic                evict;
        logic                writeback;
        mesi_e               mesi;
    } cache_resp_t;

endpackage

`default_nettype wire

//--- source/cache_cmd_pkg.sv
// trace command types for the split L1 controller, op codes and address views
`default_nettype none

`include "cache_cfg.svh"

package cache_cmd_pkg;

    typedef enum logic [3:0] {
        OP_DREAD  = 4'd0,
        OP_DWRITE = 4'd1,
        OP_IFETCH = 4'd2,
        OP_INVAL  = 4'd3,   // invalidate from L2
        OP_SNOOP  = 4'd4,   // snoop read from L2
        OP_CLEAR  = 4'd8
    } cache_op_e;

    typedef struct packed {
        logic [`D_TAG_W-1:0]       tag;
        logic [`D_INDEX_W-1:0]     index;
        logic [`LINE_OFFSET_W-1:0] offset;
    } d_addr_t;

    typedef struct packed {
        logic [`I_TAG_W-1:0]       tag;
        logic [`I_INDEX_W-1:0]     index;
        logic [`LINE_OFFSET_W-1:0] offset;
    } i_addr_t;

    // one address word, split differently per cache
    typedef union packed {
        d_addr_t d;
        i_addr_t i;
    } cache_addr_u;

    typedef struct packed {
        cache_op_e   op;
        cache_addr_u addr;
    } cache_cmd_t;

    typedef struct packed {
        cache_op_e             op;
        logic                  icache;
        logic [`D_INDEX_W-1:0] index;  // instruction index zero extended
        logic [`D_TAG_W:0]     tag;    // wide enough for the instruction tag
        logic                  clear;
    } dec_cmd_t;

endpackage

`default_nettype wire

//--- source/cache_cfg.svh
// cache geometry for the split L1 tag controller, address split and LRU age widths
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

`define CACHE_ADDR_W   32
`define LINE_OFFSET_W  6    // 64 byte line

// data cache, 16 sets of 8 ways
`define D_WAYS         8
`define D_INDEX_W      4
`define D_TAG_W        22

// instruction cache, 8 sets of 4 ways
`define I_WAYS         4
`define I_INDEX_W      3
`define I_TAG_W        23

`define WAY_W          3    // enough for the wider cache
`define AGE_W          3

`endif
